/* Bender.yml */
package:
  name: ode_euler

export_include_dirs:
  - include

sources:
  - logic/ode_pkg.sv
  - logic/fx_mul.sv
  - logic/fx_add.sv
  - logic/euler_step.sv
  - logic/ode_control.sv
  - logic/ode_top.sv
  - target: test
    files:
      - testbench/ode_asserts.sv
      - testbench/ode_tb.sv

/* include/ode_defs.svh */
// euler solver parameters
`ifndef ODE_DEFS_SVH
`define ODE_DEFS_SVH

// word width of every operand and result
`define ODE_WIDTH 32

// fraction bits of the q16.16 format
`define ODE_FRAC 16

// pipeline stages of the multiplier
`define ODE_MUL_LAT 2

// apb address bits
`define ODE_ADDR_W 6

// subtract, multiply and add of one step
`define ODE_STEP_LAT (`ODE_MUL_LAT + 2)

`endif

/* logic/euler_step.sv */
// euler step datapath
`include "ode_defs.svh"

module euler_step (
	input  logic         clock,
	input  logic         reset,
	input  logic         load,
	input  logic         scale_go,
	input  logic         step_go,
	input  ode_pkg::fx_t step_h,
	input  ode_pkg::fx_t gain,
	input  ode_pkg::fx_t y_init,
	input  ode_pkg::fx_t t_init,
	output ode_pkg::fx_t y_next,
	output ode_pkg::fx_t t_next,
	output logic         step_done,
	output logic         ovf
);
	import ode_pkg::*;

	localparam int MUL_LAT = `ODE_MUL_LAT;
	localparam int STEP_LAT = `ODE_STEP_LAT;

	fx_t y_q;
	fx_t t_q;
	fx_t scale_q;
	fx_t y_cur;
	fx_t t_cur;
	fx_t hk;
	fx_t diff;
	fx_t prod;
	fx_t t_sum;
	fx_t y_dly [STEP_LAT-1];
	fx_t t_dly [STEP_LAT-1];
	logic hk_ovf;
	logic diff_ovf;
	logic prod_ovf;
	logic y_ovf;
	logic t_ovf;
	logic [MUL_LAT-1:0] scale_v;
	logic [STEP_LAT-1:0] step_v;
	logic scale_done;
	logic early_ovf;
	logic step_ovf_q;

	// back to back steps take the new state straight from the adders
	assign y_cur = step_done ? y_next : y_q;
	assign t_cur = step_done ? t_next : t_q;

	fx_mul scale_mul (.clock(clock), .reset(reset), .a(step_h), .b(gain), .p(hk), .ovf(hk_ovf));
	fx_add diff_sub (.clock(clock), .reset(reset), .a(t_cur), .b(y_cur), .sub(1'b1),
		.s(diff), .ovf(diff_ovf));
	fx_mul diff_mul (.clock(clock), .reset(reset), .a(scale_q), .b(diff), .p(prod),
		.ovf(prod_ovf));
	fx_add y_add (.clock(clock), .reset(reset), .a(y_dly[STEP_LAT-2]), .b(prod), .sub(1'b0),
		.s(y_next), .ovf(y_ovf));
	fx_add t_add (.clock(clock), .reset(reset), .a(t_cur), .b(step_h), .sub(1'b0),
		.s(t_sum), .ovf(t_ovf));

	assign scale_done = scale_v[MUL_LAT-1];
	assign step_done = step_v[STEP_LAT-1];
	assign t_next = t_dly[STEP_LAT-2];

	// flags of the subtract, t add and multiply, held until the step ends
	assign early_ovf = (step_v[0] & (diff_ovf | t_ovf)) | (step_v[MUL_LAT] & prod_ovf);
	assign ovf = (scale_done & hk_ovf) | (step_done & (step_ovf_q | y_ovf));

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			scale_v <= '0;
			step_v <= '0;
			step_ovf_q <= 1'b0;
		end
		else
		begin
			scale_v <= {scale_v[MUL_LAT-2:0], scale_go};
			step_v <= {step_v[STEP_LAT-2:0], step_go};
			step_ovf_q <= early_ovf | (step_ovf_q & !step_done);
		end
	end

	always_ff @(posedge clock)
	begin
		if (load)
		begin
			y_q <= y_init;
			t_q <= t_init;
		end
		else if (step_done)
		begin
			y_q <= y_next;
			t_q <= t_next;
		end
		if (scale_done)
			scale_q <= hk;
		// y waits for the product, t+h waits for the y update
		y_dly[0] <= y_cur;
		t_dly[0] <= t_sum;
		for (int i = 1; i < STEP_LAT-1; i++)
		begin
			y_dly[i] <= y_dly[i-1];
			t_dly[i] <= t_dly[i-1];
		end
	end

endmodule

/* logic/fx_add.sv */
// saturating fixed point adder
`include "ode_defs.svh"

module fx_add (
	input  logic         clock,
	input  logic         reset,
	input  ode_pkg::fx_t a,
	input  ode_pkg::fx_t b,
	input  logic         sub,
	output ode_pkg::fx_t s,
	output logic         ovf
);
	import ode_pkg::*;

	localparam int W = `ODE_WIDTH;

	logic signed [W:0] sum;
	logic wrap;
	fx_t sat;

	// one guard bit catches signed overflow
	assign sum = sub ? (a - b) : (a + b);
	assign wrap = (sum[W] != sum[W-1]);

	// guard bit holds the true sign when the word wraps
	assign sat = wrap ? (sum[W] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}}) :
		sum[W-1:0];

	always_ff @(posedge clock)
	begin
		s <= sat;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			ovf <= 1'b0;
		else
			ovf <= wrap;
	end

endmodule

/* logic/fx_mul.sv */
// saturating fixed point multiplier
`include "ode_defs.svh"

module fx_mul (
	input  logic         clock,
	input  logic         reset,
	input  ode_pkg::fx_t a,
	input  ode_pkg::fx_t b,
	output ode_pkg::fx_t p,
	output logic         ovf
);
	import ode_pkg::*;

	localparam int W = $bits(fx_t);
	localparam int LAT = `ODE_MUL_LAT;

	logic signed [2*W-1:0] full;
	logic signed [2*W-1:0] shifted;
	logic fits;
	fx_t sat;
	fx_t p_pipe [LAT];
	logic ovf_pipe [LAT];

	// full product, then drop fraction bits toward minus infinity
	assign full = a * b;
	assign shifted = full >>> `ODE_FRAC;

	// upper bits must all repeat the sign of the kept word
	assign fits = (shifted[2*W-1:W-1] == {(W+1){shifted[W-1]}});
	assign sat = fits ? shifted[W-1:0] :
		(full[2*W-1] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}});

	always_ff @(posedge clock)
	begin
		p_pipe[0] <= sat;
		for (int i = 1; i < LAT; i++)
			p_pipe[i] <= p_pipe[i-1];
	end

	// overflow flag rides next to the product
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < LAT; i++)
				ovf_pipe[i] <= 1'b0;
		end
		else
		begin
			ovf_pipe[0] <= !fits;
			for (int i = 1; i < LAT; i++)
				ovf_pipe[i] <= ovf_pipe[i-1];
		end
	end

	assign p = p_pipe[LAT-1];
	assign ovf = ovf_pipe[LAT-1];

endmodule

/* logic/ode_control.sv */
// apb registers and step sequencer
`include "ode_defs.svh"

module ode_control (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`ODE_ADDR_W-1:0] paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pslverr,
	output logic                   load,
	output logic                   scale_go,
	output logic                   step_go,
	output ode_pkg::fx_t           step_h,
	output ode_pkg::fx_t           gain,
	output ode_pkg::fx_t           y_init,
	output ode_pkg::fx_t           t_init,
	input  ode_pkg::fx_t           y_next,
	input  ode_pkg::fx_t           t_next,
	input  logic                   step_done,
	input  logic                   ovf,
	output logic                   irq
);
	import ode_pkg::*;

	reg_addr_e addr;
	seq_state_e state;
	fx_t y_result;
	fx_t t_result;
	logic [31:0] count;
	logic [31:0] remaining;
	logic [3:0] wait_cnt;
	logic busy;
	logic done;
	logic overflow;
	logic step_go_q;
	logic access;
	logic mapped;
	logic writable;
	logic wr_ok;
	logic start;
	logic final_step;

	assign addr = reg_addr_e'(paddr);
	assign access = psel & penable;
	assign busy = (state != ST_IDLE);

	always_comb
	begin
		prdata = '0;
		mapped = 1'b1;
		writable = 1'b1;
		case (addr)
			ADDR_CTRL: prdata = '0;
			ADDR_STATUS:
			begin
				prdata = {29'd0, overflow, done, busy};
				writable = 1'b0;
			end
			ADDR_STEP_H: prdata = step_h;
			ADDR_GAIN: prdata = gain;
			ADDR_Y_INIT: prdata = y_init;
			ADDR_T_INIT: prdata = t_init;
			ADDR_COUNT: prdata = count;
			ADDR_Y_RESULT:
			begin
				prdata = y_result;
				writable = 1'b0;
			end
			ADDR_T_RESULT:
			begin
				prdata = t_result;
				writable = 1'b0;
			end
			default:
			begin
				mapped = 1'b0;
				writable = 1'b0;
			end
		endcase
	end

	// config writes are refused while a run is active
	assign pslverr = access & (!mapped | (pwrite & writable & busy));
	assign wr_ok = access & pwrite & writable & !busy;
	assign start = wr_ok & (addr == ADDR_CTRL) & pwdata[0];
	assign final_step = (state == ST_STEP) & step_done & (remaining == 32'd1);

	// first step after the scale wait, then chained on each step_done
	assign step_go = step_go_q | ((state == ST_STEP) & step_done & (remaining != 32'd1));

	always_ff @(posedge clock)
	begin
		if (wr_ok)
		begin
			case (addr)
				ADDR_STEP_H: step_h <= pwdata;
				ADDR_GAIN: gain <= pwdata;
				ADDR_Y_INIT: y_init <= pwdata;
				ADDR_T_INIT: t_init <= pwdata;
				ADDR_COUNT: count <= pwdata;
				default: ;
			endcase
		end
		if (final_step)
		begin
			y_result <= y_next;
			t_result <= t_next;
		end
		else if (state == ST_FINISH)
		begin
			y_result <= y_init;
			t_result <= t_init;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			done <= 1'b0;
			overflow <= 1'b0;
			irq <= 1'b0;
			load <= 1'b0;
			scale_go <= 1'b0;
			step_go_q <= 1'b0;
			remaining <= '0;
			wait_cnt <= '0;
		end
		else
		begin
			load <= 1'b0;
			scale_go <= 1'b0;
			step_go_q <= 1'b0;
			irq <= 1'b0;
			// overflow is sticky for the whole run
			if (busy)
				overflow <= overflow | ovf;
			case (state)
				ST_IDLE:
				begin
					if (start)
					begin
						done <= 1'b0;
						overflow <= 1'b0;
						remaining <= count;
						if (count == 32'd0)
							state <= ST_FINISH;
						else
						begin
							load <= 1'b1;
							scale_go <= 1'b1;
							wait_cnt <= 4'(`ODE_MUL_LAT - 1);
							state <= ST_SCALE;
						end
					end
				end
				ST_SCALE:
				begin
					if (wait_cnt == 4'd0)
					begin
						step_go_q <= 1'b1;
						state <= ST_STEP;
					end
					else
						wait_cnt <= wait_cnt - 4'd1;
				end
				ST_STEP:
				begin
					if (step_done)
						remaining <= remaining - 32'd1;
					if (final_step)
					begin
						done <= 1'b1;
						irq <= 1'b1;
						state <= ST_IDLE;
					end
				end
				ST_FINISH:
				begin
					done <= 1'b1;
					irq <= 1'b1;
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

/* logic/ode_pkg.sv */
// euler solver types
`include "ode_defs.svh"

package ode_pkg;

	// signed q16.16 word
	typedef logic signed [`ODE_WIDTH-1:0] fx_t;

	// apb register offsets
	typedef enum logic [`ODE_ADDR_W-1:0] {
		ADDR_CTRL     = 6'h00,
		ADDR_STATUS   = 6'h04,
		ADDR_STEP_H   = 6'h08,
		ADDR_GAIN     = 6'h0C,
		ADDR_Y_INIT   = 6'h10,
		ADDR_T_INIT   = 6'h14,
		ADDR_COUNT    = 6'h18,
		ADDR_Y_RESULT = 6'h1C,
		ADDR_T_RESULT = 6'h20
	} reg_addr_e;

	// step sequencer
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SCALE,
		ST_STEP,
		ST_FINISH
	} seq_state_e;

endpackage

/* logic/ode_top.sv */
// euler solver top level
`include "ode_defs.svh"

module ode_top (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`ODE_ADDR_W-1:0] paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pslverr,
	output logic                   irq
);
	import ode_pkg::*;

	logic load;
	logic scale_go;
	logic step_go;
	logic step_done;
	logic ovf;
	fx_t step_h;
	fx_t gain;
	fx_t y_init;
	fx_t t_init;
	fx_t y_next;
	fx_t t_next;

	// register file and sequencer
	ode_control u_control (
		.clock(clock),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pslverr(pslverr),
		.load(load),
		.scale_go(scale_go),
		.step_go(step_go),
		.step_h(step_h),
		.gain(gain),
		.y_init(y_init),
		.t_init(t_init),
		.y_next(y_next),
		.t_next(t_next),
		.step_done(step_done),
		.ovf(ovf),
		.irq(irq)
	);

	// arithmetic for one step, keeps y and t between steps
	euler_step u_step (
		.clock(clock),
		.reset(reset),
		.load(load),
		.scale_go(scale_go),
		.step_go(step_go),
		.step_h(step_h),
		.gain(gain),
		.y_init(y_init),
		.t_init(t_init),
		.y_next(y_next),
		.t_next(t_next),
		.step_done(step_done),
		.ovf(ovf)
	);

endmodule

/* sim.f */
+incdir+include
logic/ode_pkg.sv
logic/fx_mul.sv
logic/fx_add.sv
logic/euler_step.sv
logic/ode_control.sv
logic/ode_top.sv
testbench/ode_asserts.sv
testbench/ode_tb.sv

/* testbench/ode_asserts.sv */
// control protocol assertions
module ode_asserts (
	input logic                clock,
	input logic                reset,
	input logic                psel,
	input logic                penable,
	input logic                pslverr,
	input logic                irq,
	input logic                busy,
	input logic                step_go,
	input ode_pkg::fx_t        step_h,
	input ode_pkg::fx_t        gain,
	input ode_pkg::fx_t        y_init,
	input ode_pkg::fx_t        t_init,
	input logic [31:0]         count,
	input ode_pkg::seq_state_e state
);
	import ode_pkg::*;

	// number of failed assertions, read at the end of the run
	int fail_count = 0;

	// error response only in the access phase, and a refused write leaves the registers alone
	assert property (@(posedge clock) disable iff (reset)
		pslverr |-> (psel && penable) ##1 ($stable(step_h) && $stable(gain) &&
			$stable(y_init) && $stable(t_init) && $stable(count)))
	else
	begin
		$error("pslverr outside an access cycle or a refused write took effect");
		fail_count = fail_count + 1;
	end

	// irq is a single pulse
	assert property (@(posedge clock) disable iff (reset)
		irq |=> !irq)
	else
	begin
		$error("irq held longer than one cycle");
		fail_count = fail_count + 1;
	end

	// busy has just dropped when irq fires
	assert property (@(posedge clock) disable iff (reset)
		irq |-> !busy && $past(busy))
	else
	begin
		$error("irq not aligned with the end of busy");
		fail_count = fail_count + 1;
	end

	assert property (@(posedge clock) disable iff (reset)
		step_go |-> state != ST_IDLE)
	else
	begin
		$error("step_go while the sequencer is idle");
		fail_count = fail_count + 1;
	end

endmodule

bind ode_control ode_asserts u_asserts (.*);

/* testbench/ode_tb.sv */
// euler solver testbench
`include "ode_defs.svh"

module ode_tb;
	import ode_pkg::*;

	// one run of the solver and what it should report
	typedef struct packed {
		logic [31:0] h;
		logic [31:0] k;
		logic [31:0] y0;
		logic [31:0] t0;
		logic [31:0] count;
		logic        ovf;
		logic        perr;
	} row_t;

	localparam int ROWS = 7;
	localparam longint FX_MAX = 64'sd2147483647;
	localparam longint FX_MIN = -64'sd2147483648;

	logic clock;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`ODE_ADDR_W-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pslverr;
	logic irq;

	row_t rows [ROWS];
	int errors = 0;
	int passed = 0;
	int failed = 0;
	int irq_count = 0;
	int cycles = 0;
	int cycle_limit = 0;

	ode_top dut (
		.clock(clock),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pslverr(pslverr),
		.irq(irq)
	);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// irq pulses counted on the falling edge, where irq is stable
	always @(negedge clock)
	begin
		if (irq === 1'b1)
			irq_count = irq_count + 1;
	end

	initial
	begin
		wait (cycle_limit != 0);
		while (cycles < cycle_limit)
		begin
			@(posedge clock);
			cycles = cycles + 1;
		end
		$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
		$display("*** FAILED ***");
		$finish;
	end

	task automatic apb_write(input logic [`ODE_ADDR_W-1:0] addr, input logic [31:0] data,
		output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clock);
		#10;
		penable = 1'b1;
		@(negedge clock);
		err = pslverr;
		@(posedge clock);
		#10;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [`ODE_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clock);
		#10;
		penable = 1'b1;
		@(negedge clock);
		data = prdata;
		err = pslverr;
		@(posedge clock);
		#10;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic compare_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
			errors = errors + 1;
		end
	endtask

	task automatic config_write(input logic [`ODE_ADDR_W-1:0] addr, input logic [31:0] data);
		logic err;
		apb_write(addr, data, err);
		if (err !== 1'b0)
		begin
			$display("error at %0t: write of %h to %h got pslverr", $time, data, addr);
			errors = errors + 1;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		if (errors == start_errors)
		begin
			$display("%s: pass", name);
			passed = passed + 1;
		end
		else
		begin
			$display("%s: fail, %0d errors", name, errors - start_errors);
			failed = failed + 1;
		end
	endtask

	// q16.16 product, truncated toward minus infinity, saturated
	task automatic q16_mul(input fx_t a, input fx_t b, output fx_t p, output logic f);
		longint full;
		longint shifted;
		full = longint'(a) * longint'(b);
		shifted = full >>> `ODE_FRAC;
		f = (shifted > FX_MAX) || (shifted < FX_MIN);
		if (shifted > FX_MAX)
			p = 32'h7FFF_FFFF;
		else if (shifted < FX_MIN)
			p = 32'h8000_0000;
		else
			p = shifted[31:0];
	endtask

	task automatic sat_addsub(input fx_t a, input fx_t b, input logic sub, output fx_t s,
		output logic f);
		longint sum;
		sum = sub ? (longint'(a) - longint'(b)) : (longint'(a) + longint'(b));
		f = (sum > FX_MAX) || (sum < FX_MIN);
		if (sum > FX_MAX)
			s = 32'h7FFF_FFFF;
		else if (sum < FX_MIN)
			s = 32'h8000_0000;
		else
			s = sum[31:0];
	endtask

	// h*k once, then y += hk*(t-y) and t += h per step
	task automatic euler_model(input row_t r, output fx_t y, output fx_t t);
		fx_t hk;
		fx_t d;
		fx_t p;
		logic f;
		y = r.y0;
		t = r.t0;
		q16_mul(r.h, r.k, hk, f);
		for (int n = 0; n < r.count; n++)
		begin
			sat_addsub(t, y, 1'b1, d, f);
			q16_mul(hk, d, p, f);
			sat_addsub(y, p, 1'b0, y, f);
			sat_addsub(t, r.h, 1'b0, t, f);
		end
	endtask

	task automatic register_readback();
		logic [`ODE_ADDR_W-1:0] addrs [5];
		logic [31:0] vals [5];
		logic [31:0] data;
		logic err;
		int start_errors;
		start_errors = errors;
		addrs = '{ADDR_STEP_H, ADDR_GAIN, ADDR_Y_INIT, ADDR_T_INIT, ADDR_COUNT};
		vals = '{32'h1234_5678, 32'h8765_4321, 32'hFFFF_0001, 32'h0000_FFFF, 32'h0000_0007};
		apb_read(ADDR_STATUS, data, err);
		compare_word("status after reset", data, 32'd0);
		for (int n = 0; n < 5; n++)
			config_write(addrs[n], vals[n]);
		for (int n = 0; n < 5; n++)
		begin
			apb_read(addrs[n], data, err);
			compare_word($sformatf("readback of %h", addrs[n]), data, vals[n]);
		end
		report_test("register readback", start_errors);
	endtask

	task automatic unmapped_access();
		logic [31:0] data;
		logic err;
		int start_errors;
		start_errors = errors;
		apb_read(6'h24, data, err);
		compare_word("pslverr on read of 24", err, 1'b1);
		apb_write(6'h3C, 32'hFFFF_FFFF, err);
		compare_word("pslverr on write to 3c", err, 1'b1);
		apb_read(6'h02, data, err);
		compare_word("pslverr on read of 02", err, 1'b1);
		apb_read(ADDR_STATUS, data, err);
		compare_word("pslverr on status read", err, 1'b0);
		report_test("unmapped addresses", start_errors);
	endtask

	task automatic run_row(input int i);
		row_t r;
		fx_t exp_y;
		fx_t exp_t;
		logic [31:0] data;
		logic err;
		int start_errors;
		int base;
		int waited;
		r = rows[i];
		start_errors = errors;
		euler_model(r, exp_y, exp_t);
		config_write(ADDR_STEP_H, r.h);
		config_write(ADDR_GAIN, r.k);
		config_write(ADDR_Y_INIT, r.y0);
		config_write(ADDR_T_INIT, r.t0);
		config_write(ADDR_COUNT, r.count);
		base = irq_count;
		config_write(ADDR_CTRL, 32'd1);
		// gain write probe, refused while the run is active
		apb_write(ADDR_GAIN, r.k ^ 32'h0005_0000, err);
		compare_word("pslverr of gain write during run", err, r.perr);
		if (r.count != 0)
		begin
			apb_read(ADDR_STATUS, data, err);
			compare_word("pslverr of status read during run", err, 1'b0);
			compare_word("busy and done during run", data[1:0], 2'b01);
		end
		waited = 0;
		while (irq_count == base && waited < 20 + 4 * r.count)
		begin
			@(posedge clock);
			#10;
			waited = waited + 1;
		end
		if (irq_count == base)
		begin
			$display("row %0d: irq never arrived, the run did not finish", i);
			errors = errors + 1;
		end
		else
		begin
			apb_read(ADDR_Y_RESULT, data, err);
			compare_word("y_result", data, exp_y);
			apb_read(ADDR_T_RESULT, data, err);
			compare_word("t_result", data, exp_t);
			apb_read(ADDR_STATUS, data, err);
			compare_word("status after run", data, {29'd0, r.ovf, 2'b10});
		end
		report_test($sformatf("row %0d", i), start_errors);
	endtask

	initial
	begin
		int limit;
		int assert_fails;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		// h, k, y0, t0, count, overflow, pslverr of the gain probe
		rows[0] = '{32'h0000_4000, 32'h0001_0000, 32'h0000_0000, 32'h0000_0000, 32'd4, 1'b0, 1'b1};
		rows[1] = '{32'h0000_8000, 32'hFFFE_0000, 32'h0003_0000, 32'hFFFF_0000, 32'd3, 1'b0, 1'b1};
		rows[2] = '{32'h0000_199A, 32'h0001_8000, 32'h0001_4000, 32'h0002_0000, 32'd6, 1'b0, 1'b1};
		rows[3] = '{32'h0001_0000, 32'h0001_0000, 32'hFFFA_8000, 32'h0007_4000, 32'd0, 1'b0, 1'b0};
		rows[4] = '{32'h00C8_0000, 32'h0190_0000, 32'h0001_0000, 32'h0064_0000, 32'd2, 1'b1, 1'b1};
		rows[5] = '{32'hFFFF_4000, 32'h0000_8000, 32'hFFFE_0000, 32'h000A_0000, 32'd5, 1'b0, 1'b1};
		rows[6] = '{32'h4000_0000, 32'h0000_0001, 32'h7000_0000, 32'h7000_0000, 32'd2, 1'b1, 1'b1};
		limit = 0;
		for (int i = 0; i < ROWS; i++)
			limit = limit + 8 + 4 * rows[i].count + 50;
		cycle_limit = limit;
		repeat (5) @(posedge clock);
		#10;
		reset = 1'b0;
		register_readback();
		unmapped_access();
		for (int i = 0; i < ROWS; i++)
			run_row(i);
		assert_fails = dut.u_control.u_asserts.fail_count;
		$display("tests passed: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
			passed, failed, errors, assert_fails);
		if (failed == 0 && assert_fails == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
